// File: hdl/link_pkg.sv
package link_pkg;

  // One byte per stream beat, the CRC is defined over bytes
  localparam int DATA_W = 8;

  // CRC-8 with x^8 + x^2 + x + 1, processed MSB first
  localparam logic [DATA_W-1:0] CRC_POLY = 8'h07;
  localparam logic [DATA_W-1:0] CRC_INIT = 8'h00;

  // Advance the CRC by one byte
  function automatic logic [DATA_W-1:0] crc8_next(input logic [DATA_W-1:0] crc,
                                                  input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] c;
    c = crc ^ data;
    for (int i = 0; i < DATA_W; i++) begin
      if (c[DATA_W-1]) begin
        c = (c << 1) ^ CRC_POLY;
      end else begin
        c = c << 1;
      end
    end
    return c;
  endfunction

endpackage

// File: hdl/csr_pkg.sv
package csr_pkg;

  // APB bus widths
  localparam int APB_AW = 4;
  localparam int APB_DW = 32;

  // Register map
  localparam logic [APB_AW-1:0] ADDR_STATUS     = 4'h0;
  localparam logic [APB_AW-1:0] ADDR_CMD        = 4'h4;
  localparam logic [APB_AW-1:0] ADDR_OK_COUNT   = 4'h8;
  localparam logic [APB_AW-1:0] ADDR_DROP_COUNT = 4'hC;

  // STATUS holds the FIFO level in 7:0 and the held flag above it
  localparam int STATUS_HELD_BIT = 8;

  // Host commands written to CMD
  typedef enum logic [7:0] {
    CMD_ACK = 8'h01,
    CMD_NAK = 8'h02
  } host_cmd_e;

endpackage

// File: hdl/crc8_check.sv
module crc8_check (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        s_tvalid_i,
  input  logic                        s_tready_i,
  input  logic                        s_tkeep_i,
  input  logic                        s_tlast_i,
  input  logic [link_pkg::DATA_W-1:0] s_tdata_i,
  output logic                        save_o,
  output logic                        drop_o
);
  import link_pkg::*;

  logic [DATA_W-1:0] crc_q;
  logic [DATA_W-1:0] crc_d;
  logic              xfer;
  logic              frame_end;

  assign xfer      = s_tvalid_i && s_tready_i;
  assign frame_end = xfer && s_tlast_i;

  // Beats with tkeep low pass through without touching the CRC
  assign crc_d = (xfer && s_tkeep_i) ? crc8_next(crc_q, s_tdata_i) : crc_q;

  // The trailing CRC byte is part of the running sum,
  // so an intact frame leaves a zero remainder
  assign save_o = frame_end && (crc_d == '0);
  assign drop_o = frame_end && (crc_d != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      crc_q <= CRC_INIT;
    end else if (frame_end) begin
      // Next frame starts from a clean CRC
      crc_q <= CRC_INIT;
    end else begin
      crc_q <= crc_d;
    end
  end

endmodule

// File: hdl/axis_skid.sv
module axis_skid #(
  parameter int BYPASS = 0
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        s_tvalid_i,
  output logic                        s_tready_o,
  input  logic                        s_tlast_i,
  input  logic [link_pkg::DATA_W-1:0] s_tdata_i,
  output logic                        m_tvalid_o,
  input  logic                        m_tready_i,
  output logic                        m_tlast_o,
  output logic [link_pkg::DATA_W-1:0] m_tdata_o
);
  import link_pkg::*;

  generate
    if (BYPASS != 0) begin : g_bypass

      assign s_tready_o = m_tready_i;
      assign m_tvalid_o = s_tvalid_i;
      assign m_tlast_o  = s_tlast_i;
      assign m_tdata_o  = s_tdata_i;

    end else begin : g_skid

      logic              main_valid;
      logic              main_last;
      logic [DATA_W-1:0] main_data;
      logic              skid_valid;
      logic              skid_last;
      logic [DATA_W-1:0] skid_data;
      logic              ready_q;
      logic              take;
      logic              pop;

      assign take = s_tvalid_i && ready_q;
      // Output register is free to load this cycle
      assign pop  = !main_valid || m_tready_i;

      always_ff @(posedge clock) begin
        if (reset) begin
          main_valid <= 1'b0;
          skid_valid <= 1'b0;
          ready_q    <= 1'b0;
        end else if (pop) begin
          main_valid <= skid_valid || take;
          skid_valid <= 1'b0;
          ready_q    <= 1'b1;
        end else if (take) begin
          // Sink stalled, park the beat and close the input
          skid_valid <= 1'b1;
          ready_q    <= 1'b0;
        end
      end

      always_ff @(posedge clock) begin
        if (pop && skid_valid) begin
          {main_last, main_data} <= {skid_last, skid_data};
        end else if (pop && take) begin
          {main_last, main_data} <= {s_tlast_i, s_tdata_i};
        end
        if (!pop && take) begin
          {skid_last, skid_data} <= {s_tlast_i, s_tdata_i};
        end
      end

      assign s_tready_o = ready_q;
      assign m_tvalid_o = main_valid;
      assign m_tlast_o  = main_last;
      assign m_tdata_o  = main_data;

    end
  endgenerate

endmodule

// File: hdl/packet_fifo.sv
module packet_fifo #(
  parameter int DEPTH  = 32,
  parameter int OUTREG = 2
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        s_tvalid_i,
  output logic                        s_tready_o,
  input  logic                        s_tkeep_i,
  input  logic                        s_tlast_i,
  input  logic [link_pkg::DATA_W-1:0] s_tdata_i,
  input  logic                        save_i,
  input  logic                        drop_i,
  input  logic                        next_i,
  input  logic                        redo_i,
  output logic [7:0]                  level_o,
  output logic                        held_o,
  output logic                        m_tvalid_o,
  input  logic                        m_tready_i,
  output logic                        m_tlast_o,
  output logic [link_pkg::DATA_W-1:0] m_tdata_o
);
  import link_pkg::*;

  localparam int ABITS = $clog2(DEPTH);
  localparam int PW    = ABITS + 1;

  // Host command waiting for the output path to drain
  typedef enum logic [1:0] {
    PEND_NONE,
    PEND_ACK,
    PEND_NAK
  } pend_e;

  // Each entry holds the last flag above the data byte
  logic [DATA_W:0] mem [DEPTH];

  logic [PW-1:0]     wr_ptr;
  logic [PW-1:0]     commit_ptr;
  logic [PW-1:0]     rd_ptr;
  logic [PW-1:0]     rel_ptr;
  logic [PW-1:0]     wr_next;
  logic [PW-1:0]     used_next;
  logic [PW-1:0]     level_w;
  logic [7:0]        level_q;
  logic              ready_q;
  logic              store;
  logic              empty;
  logic              fetch;
  logic              fetch_q;
  logic              frame_end;
  logic              held_q;
  logic              f_valid;
  logic              f_last;
  logic [DATA_W-1:0] f_data;
  logic              f_ready;
  logic              drained;
  logic              cmd_go;
  pend_e             pend_q;

  // Write side
  assign s_tready_o = ready_q;
  assign store      = s_tvalid_i && ready_q && s_tkeep_i && !drop_i;

  // A dropped frame rewinds to the last committed boundary
  assign wr_next   = drop_i ? commit_ptr : wr_ptr + PW'(store);
  // Space is only returned once the host acknowledges a frame
  assign used_next = wr_next - rel_ptr;

  always_ff @(posedge clock) begin
    if (store) begin
      mem[wr_ptr[ABITS-1:0]] <= {s_tlast_i, s_tdata_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
      ready_q    <= 1'b0;
    end else begin
      wr_ptr  <= wr_next;
      // Top bit set means DEPTH entries in use
      ready_q <= !used_next[ABITS];
      if (save_i) begin
        commit_ptr <= wr_next;
      end
    end
  end

  // Read side, only committed data is visible
  assign empty     = (rd_ptr == commit_ptr);
  // Last beat of the frame just landed in the fetch register
  assign frame_end = fetch_q && f_last;
  assign drained   = !f_valid && !m_tvalid_o;
  assign cmd_go    = (pend_q != PEND_NONE) && drained;
  assign fetch     = !empty && !held_q && !frame_end && !cmd_go && (!f_valid || f_ready);

  // Registered memory read
  always_ff @(posedge clock) begin
    if (fetch) begin
      {f_last, f_data} <= mem[rd_ptr[ABITS-1:0]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr  <= '0;
      rel_ptr <= '0;
      f_valid <= 1'b0;
      fetch_q <= 1'b0;
      held_q  <= 1'b0;
      pend_q  <= PEND_NONE;
    end else begin
      fetch_q <= fetch;

      if (fetch) begin
        f_valid <= 1'b1;
      end else if (f_ready) begin
        f_valid <= 1'b0;
      end

      // Stop and wait after a complete frame has been fetched
      if (frame_end) begin
        held_q <= 1'b1;
      end else if (cmd_go) begin
        held_q <= 1'b0;
      end

      // A newer command replaces one still pending
      if (next_i) begin
        pend_q <= PEND_ACK;
      end else if (redo_i) begin
        pend_q <= PEND_NAK;
      end else if (cmd_go) begin
        pend_q <= PEND_NONE;
      end

      // NAK replays from the release point
      if (cmd_go && pend_q == PEND_NAK) begin
        rd_ptr <= rel_ptr;
      end else if (fetch) begin
        rd_ptr <= rd_ptr + PW'(1);
      end

      if (cmd_go && pend_q == PEND_ACK) begin
        rel_ptr <= rd_ptr;
      end
    end
  end

  // Occupancy counts everything not yet released
  assign level_w = wr_ptr - rel_ptr;

  always_ff @(posedge clock) begin
    if (reset) begin
      level_q <= '0;
    end else begin
      level_q <= 8'(level_w);
    end
  end

  assign level_o = level_q;
  assign held_o  = held_q;

  axis_skid #(
    .BYPASS(OUTREG == 1 ? 1 : 0)
  ) axis_skid_i (
    .clock     (clock),
    .reset     (reset),
    .s_tvalid_i(f_valid),
    .s_tready_o(f_ready),
    .s_tlast_i (f_last),
    .s_tdata_i (f_data),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o)
  );

endmodule

// File: hdl/link_csr.sv
module link_csr #(
  parameter int CNT_W = 16
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [csr_pkg::APB_AW-1:0]  paddr_i,
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [csr_pkg::APB_DW-1:0]  pwdata_i,
  output logic [csr_pkg::APB_DW-1:0]  prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  input  logic                        save_i,
  input  logic                        drop_i,
  input  logic [7:0]                  level_i,
  input  logic                        held_i,
  output logic                        next_o,
  output logic                        redo_o
);
  import csr_pkg::*;

  logic [CNT_W-1:0] ok_q;
  logic [CNT_W-1:0] drop_q;
  logic [7:0]       opcode;
  logic             access;
  logic             cmd_write;
  logic             err;

  // No wait states, every transfer is setup then access
  assign pready_o  = 1'b1;
  assign access    = psel_i && penable_i;
  assign opcode    = pwdata_i[7:0];
  assign cmd_write = access && pwrite_i && (paddr_i == ADDR_CMD);

  // Command strobes last exactly the access cycle
  assign next_o = cmd_write && (opcode == CMD_ACK);
  assign redo_o = cmd_write && (opcode == CMD_NAK);

  always_comb begin
    prdata_o = '0;
    err      = 1'b0;
    case (paddr_i)
      ADDR_STATUS: begin
        if (pwrite_i) begin
          err = 1'b1;
        end else begin
          prdata_o[STATUS_HELD_BIT:0] = {held_i, level_i};
        end
      end
      ADDR_CMD: begin
        // Write only, reads return zero
        if (pwrite_i) begin
          err = (opcode != CMD_ACK) && (opcode != CMD_NAK);
        end
      end
      ADDR_OK_COUNT: begin
        if (pwrite_i) begin
          err = 1'b1;
        end else begin
          prdata_o = APB_DW'(ok_q);
        end
      end
      ADDR_DROP_COUNT: begin
        if (pwrite_i) begin
          err = 1'b1;
        end else begin
          prdata_o = APB_DW'(drop_q);
        end
      end
      default: err = 1'b1;
    endcase
  end

  assign pslverr_o = access && err;

  // Frame counters stick at all ones
  always_ff @(posedge clock) begin
    if (reset) begin
      ok_q   <= '0;
      drop_q <= '0;
    end else begin
      if (save_i && !(&ok_q)) begin
        ok_q <= ok_q + 1'b1;
      end
      if (drop_i && !(&drop_q)) begin
        drop_q <= drop_q + 1'b1;
      end
    end
  end

endmodule

// File: hdl/link_rx_top.sv
module link_rx_top #(
  parameter int DEPTH  = 32,
  parameter int OUTREG = 2,
  parameter int CNT_W  = 16
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        s_tvalid_i,
  output logic                        s_tready_o,
  input  logic                        s_tkeep_i,
  input  logic                        s_tlast_i,
  input  logic [link_pkg::DATA_W-1:0] s_tdata_i,
  output logic                        m_tvalid_o,
  input  logic                        m_tready_i,
  output logic                        m_tlast_o,
  output logic [link_pkg::DATA_W-1:0] m_tdata_o,
  input  logic [csr_pkg::APB_AW-1:0]  paddr_i,
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [csr_pkg::APB_DW-1:0]  pwdata_i,
  output logic [csr_pkg::APB_DW-1:0]  prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o
);

  logic       save;
  logic       drop;
  logic       next_cmd;
  logic       redo_cmd;
  logic [7:0] level;
  logic       held;

  // Checker judges each frame as the FIFO accepts it
  crc8_check crc8_check_i (
    .clock     (clock),
    .reset     (reset),
    .s_tvalid_i(s_tvalid_i),
    .s_tready_i(s_tready_o),
    .s_tkeep_i (s_tkeep_i),
    .s_tlast_i (s_tlast_i),
    .s_tdata_i (s_tdata_i),
    .save_o    (save),
    .drop_o    (drop)
  );

  packet_fifo #(
    .DEPTH (DEPTH),
    .OUTREG(OUTREG)
  ) packet_fifo_i (
    .clock     (clock),
    .reset     (reset),
    .s_tvalid_i(s_tvalid_i),
    .s_tready_o(s_tready_o),
    .s_tkeep_i (s_tkeep_i),
    .s_tlast_i (s_tlast_i),
    .s_tdata_i (s_tdata_i),
    .save_i    (save),
    .drop_i    (drop),
    .next_i    (next_cmd),
    .redo_i    (redo_cmd),
    .level_o   (level),
    .held_o    (held),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o)
  );

  link_csr #(
    .CNT_W(CNT_W)
  ) link_csr_i (
    .clock    (clock),
    .reset    (reset),
    .paddr_i  (paddr_i),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .pwdata_i (pwdata_i),
    .prdata_o (prdata_o),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o),
    .save_i   (save),
    .drop_i   (drop),
    .level_i  (level),
    .held_i   (held),
    .next_o   (next_cmd),
    .redo_o   (redo_cmd)
  );

endmodule

// File: verif/link_assertions.sv
module link_assertions (
  input logic                        clock,
  input logic                        reset,
  input logic                        s_tvalid_i,
  input logic                        s_tkeep_i,
  input logic                        s_tlast_i,
  input logic                        m_tvalid_i,
  input logic                        m_tready_i,
  input logic                        m_tlast_i,
  input logic [link_pkg::DATA_W-1:0] m_tdata_i,
  input logic                        psel_i,
  input logic                        penable_i,
  input logic                        save_i,
  input logic                        drop_i
);

  // Count of failed assertions, read by the testbench at the end
  int fails = 0;

  // Output beat must hold until the sink takes it
  a_out_stable: assert property (@(posedge clock) disable iff (reset)
    m_tvalid_i && !m_tready_i |=> m_tvalid_i && $stable(m_tdata_i) && $stable(m_tlast_i))
    else begin
      fails++;
      $error("output stream changed while stalled");
    end

  // A frame verdict comes only with a tlast beat, and never both at once
  a_save_drop: assert property (@(posedge clock) disable iff (reset)
    (save_i || drop_i) |-> !(save_i && drop_i) && s_tvalid_i && s_tlast_i)
    else begin
      fails++;
      $error("save or drop outside a tlast beat, or both together");
    end

  a_last_kept: assert property (@(posedge clock) disable iff (reset)
    s_tvalid_i && s_tlast_i |-> s_tkeep_i)
    else begin
      fails++;
      $error("tlast beat with tkeep low");
    end

  // Access phase only ever follows a selected setup phase
  a_apb_enable: assert property (@(posedge clock) disable iff (reset) penable_i |-> psel_i)
    else begin
      fails++;
      $error("APB penable without psel");
    end

endmodule

// File: verif/link_checker.sv
module link_checker #(
  parameter int DEPTH = 32
) (
  input logic                        clock,
  input logic                        reset,
  input logic                        s_tvalid_i,
  input logic                        s_tready_i,
  input logic                        s_tkeep_i,
  input logic                        s_tlast_i,
  input logic [link_pkg::DATA_W-1:0] s_tdata_i,
  input logic                        m_tvalid_i,
  input logic                        m_tready_i,
  input logic                        m_tlast_i,
  input logic [link_pkg::DATA_W-1:0] m_tdata_i,
  input logic [csr_pkg::APB_AW-1:0]  paddr_i,
  input logic                        psel_i,
  input logic                        penable_i,
  input logic                        pwrite_i,
  input logic [csr_pkg::APB_DW-1:0]  pwdata_i,
  input logic [csr_pkg::APB_DW-1:0]  prdata_i,
  input logic                        pslverr_i,
  input int                          phase_i
);
  import link_pkg::*;
  import csr_pkg::*;

  // Frame being received, and the good frames still owed at the output
  logic [DATA_W-1:0] cur[$];
  logic [DATA_W-1:0] exp_bytes[$];
  int                exp_len[$];
  int                idx = 0;
  int                good_cnt = 0;
  int                bad_cnt = 0;
  int                frames_out = 0;
  int                err_count = 0;
  int                test_errs = 0;
  int                checks = 0;
  int                tests = 0;
  int                cur_phase = 0;
  logic              await_cmd = 1'b0;
  logic              saw_full = 1'b0;

  // Reference CRC, shifting one message bit at a time
  function automatic logic [DATA_W-1:0] crc_bits(input logic [DATA_W-1:0] crc,
                                                 input logic [DATA_W-1:0] b);
    logic [DATA_W-1:0] r;
    logic              fb;
    r = crc;
    for (int i = DATA_W - 1; i >= 0; i--) begin
      fb = r[DATA_W-1] ^ b[i];
      r  = {r[DATA_W-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
    end
    return r;
  endfunction

  function automatic string test_name(input int p);
    case (p)
      1:       return "random_frames";
      2:       return "nak_replay";
      3:       return "counters";
      4:       return "apb_errors";
      5:       return "backpressure";
      default: return "reset";
    endcase
  endfunction

  task automatic mismatch(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    err_count++;
    test_errs++;
    $display("ERR %s %s: expected %0h, actual %0h", test_name(cur_phase), what, expected, actual);
  endtask

  task automatic problem(input string what);
    err_count++;
    test_errs++;
    $display("%s: %s", test_name(cur_phase), what);
  endtask

  always @(posedge clock) begin : watch
    logic              exp_err;
    logic [8:0]        exp_beat;
    logic [DATA_W-1:0] crc;
    if (!reset) begin
      // Close out the previous test when the stimulus moves on
      if (phase_i != cur_phase) begin
        if (cur_phase == 5 && !saw_full) begin
          problem("s_tready_o never went low while the output was stalled");
        end
        if (cur_phase > 0) begin
          tests++;
          $display("test %s: %0d errors", test_name(cur_phase), test_errs);
        end
        test_errs = 0;
        cur_phase = phase_i;
      end

      // APB access phase, compared before this edge's frame updates
      if (psel_i && penable_i) begin
        checks++;
        case (paddr_i)
          ADDR_STATUS, ADDR_OK_COUNT, ADDR_DROP_COUNT: exp_err = pwrite_i;
          ADDR_CMD: exp_err = pwrite_i && pwdata_i[7:0] != CMD_ACK && pwdata_i[7:0] != CMD_NAK;
          default: exp_err = 1'b1;
        endcase
        if (pslverr_i !== exp_err) begin
          mismatch("pslverr", 32'(exp_err), 32'(pslverr_i));
        end
        if (!pwrite_i && paddr_i == ADDR_OK_COUNT && prdata_i !== 32'(good_cnt)) begin
          mismatch("OK_COUNT", 32'(good_cnt), prdata_i);
        end
        if (!pwrite_i && paddr_i == ADDR_DROP_COUNT && prdata_i !== 32'(bad_cnt)) begin
          mismatch("DROP_COUNT", 32'(bad_cnt), prdata_i);
        end
        if (!pwrite_i && paddr_i == ADDR_STATUS) begin
          if (prdata_i[7:0] > DEPTH || prdata_i[31:9] != '0) begin
            problem($sformatf("STATUS read %0h has a level above the FIFO depth", prdata_i));
          end
          if (await_cmd && prdata_i[STATUS_HELD_BIT] !== 1'b1) begin
            mismatch("STATUS held", 32'd1, 32'(prdata_i[STATUS_HELD_BIT]));
          end
        end
        if (pwrite_i && paddr_i == ADDR_CMD && await_cmd) begin
          if (pwdata_i[7:0] == CMD_ACK && exp_len.size() > 0) begin
            repeat (exp_len[0]) void'(exp_bytes.pop_front());
            void'(exp_len.pop_front());
            await_cmd = 1'b0;
          end else if (pwdata_i[7:0] == CMD_NAK) begin
            // Same frame is owed again
            await_cmd = 1'b0;
          end
        end
      end

      // Output beats against the head of the good frame queue
      if (m_tvalid_i && m_tready_i) begin
        checks++;
        if (await_cmd) begin
          problem("output beat while waiting for a host command");
        end else if (exp_len.size() == 0) begin
          problem("output beat with no good frame expected");
        end else begin
          exp_beat = {idx == exp_len[0] - 1, exp_bytes[idx]};
          if ({m_tlast_i, m_tdata_i} !== exp_beat) begin
            mismatch($sformatf("beat %0d of frame", idx), 32'(exp_beat),
                     32'({m_tlast_i, m_tdata_i}));
          end
          idx++;
          if (m_tlast_i) begin
            idx = 0;
            await_cmd = 1'b1;
            frames_out++;
          end
        end
      end

      // Input side, kept bytes only, judged on tlast
      if (s_tvalid_i && s_tready_i) begin
        if (s_tkeep_i) begin
          cur.push_back(s_tdata_i);
        end
        if (s_tlast_i) begin
          checks++;
          crc = CRC_INIT;
          foreach (cur[i]) begin
            crc = crc_bits(crc, cur[i]);
          end
          if (crc == '0) begin
            foreach (cur[i]) begin
              exp_bytes.push_back(cur[i]);
            end
            exp_len.push_back(cur.size());
            good_cnt++;
          end else begin
            bad_cnt++;
          end
          cur.delete();
        end
      end
      if (cur_phase == 5 && s_tvalid_i && !s_tready_i) begin
        saw_full = 1'b1;
      end
    end
  end

endmodule

// File: verif/link_tb.sv
module link_tb;
  import link_pkg::*;
  import csr_pkg::*;

  localparam int DEPTH  = 32;
  localparam int OUTREG = 2;
  localparam int CNT_W  = 16;
  localparam int TMO    = 2000;

  logic              clock = 1'b0;
  logic              reset;
  logic              s_tvalid;
  logic              s_tready;
  logic              s_tkeep;
  logic              s_tlast;
  logic [DATA_W-1:0] s_tdata;
  logic              m_tvalid;
  logic              m_tready = 1'b0;
  logic              m_tlast;
  logic [DATA_W-1:0] m_tdata;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              stall = 1'b0;
  int                phase = 0;
  // Output frames waited for so far, replays included
  int                seen = 0;

  always #20 clock = ~clock;

  // Random back-pressure on the output unless held off on purpose
  always @(posedge clock) begin
    #2;
    m_tready = !stall && ($urandom % 4 != 0);
  end

  link_rx_top #(
    .DEPTH (DEPTH),
    .OUTREG(OUTREG),
    .CNT_W (CNT_W)
  ) link_rx_top_i (
    .clock(clock), .reset(reset),
    .s_tvalid_i(s_tvalid), .s_tready_o(s_tready), .s_tkeep_i(s_tkeep),
    .s_tlast_i(s_tlast), .s_tdata_i(s_tdata),
    .m_tvalid_o(m_tvalid), .m_tready_i(m_tready), .m_tlast_o(m_tlast), .m_tdata_o(m_tdata),
    .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
  );

  link_checker #(
    .DEPTH(DEPTH)
  ) link_checker_i (
    .clock(clock), .reset(reset),
    .s_tvalid_i(s_tvalid), .s_tready_i(s_tready), .s_tkeep_i(s_tkeep),
    .s_tlast_i(s_tlast), .s_tdata_i(s_tdata),
    .m_tvalid_i(m_tvalid), .m_tready_i(m_tready), .m_tlast_i(m_tlast), .m_tdata_i(m_tdata),
    .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .pwdata_i(pwdata), .prdata_i(prdata), .pslverr_i(pslverr), .phase_i(phase)
  );

  bind link_rx_top link_assertions link_assertions_i (
    .clock(clock), .reset(reset),
    .s_tvalid_i(s_tvalid_i), .s_tkeep_i(s_tkeep_i), .s_tlast_i(s_tlast_i),
    .m_tvalid_i(m_tvalid_o), .m_tready_i(m_tready_i), .m_tlast_i(m_tlast_o),
    .m_tdata_i(m_tdata_o), .psel_i(psel_i), .penable_i(penable_i),
    .save_i(save), .drop_i(drop)
  );

  task automatic finish_run(input string reason);
    int errs;
    errs = link_checker_i.err_count + link_rx_top_i.link_assertions_i.fails;
    if (reason != "") begin
      $display("%s", reason);
    end
    $display("%0d tests, %0d checks, %0d errors", link_checker_i.tests,
             link_checker_i.checks, errs);
    if (reason == "" && errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // Called and returns a little after a rising edge
  task automatic send_beat(input logic keep, input logic last, input logic [DATA_W-1:0] data);
    logic done;
    s_tvalid = 1'b1;
    s_tkeep  = keep;
    s_tlast  = last;
    s_tdata  = data;
    done     = 1'b0;
    for (int t = 0; t < TMO && !done; t++) begin
      done = s_tready;
      @(posedge clock);
      #2;
    end
    if (!done) begin
      finish_run("timeout: s_tready_o stayed low on the input stream");
    end
  endtask

  task automatic send_frame(input logic bad, input logic long_frame);
    int                n;
    logic [DATA_W-1:0] crc;
    logic [DATA_W-1:0] b;
    n   = long_frame ? 12 : 1 + $urandom % 12;
    crc = CRC_INIT;
    for (int i = 0; i < n; i++) begin
      b = DATA_W'($urandom);
      // Gap beats carry junk that must not reach the CRC or the FIFO
      if ($urandom % 4 == 0) begin
        send_beat(1'b0, 1'b0, DATA_W'($urandom));
      end
      send_beat(1'b1, 1'b0, b);
      crc = crc8_next(crc, b);
    end
    if (bad) begin
      crc = crc ^ DATA_W'(1 + $urandom % 255);
    end
    send_beat(1'b1, 1'b1, crc);
    s_tvalid = 1'b0;
    if ($urandom % 3 == 0) begin
      @(posedge clock);
      #2;
    end
  endtask

  task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] data);
    logic done;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clock);
    #2;
    penable = 1'b1;
    done    = 1'b0;
    for (int t = 0; t < 16 && !done; t++) begin
      done = pready;
      @(posedge clock);
      #2;
    end
    psel    = 1'b0;
    penable = 1'b0;
    if (!done) begin
      finish_run("timeout: pready_o never went high");
    end
  endtask

  task automatic wait_frame();
    seen++;
    for (int t = 0; t < TMO && link_checker_i.frames_out < seen; t++) begin
      @(posedge clock);
      #2;
    end
    if (link_checker_i.frames_out < seen) begin
      finish_run("timeout: no complete frame came out of the FIFO");
    end
  endtask

  // Host side of stop-and-wait, optionally asking for replays
  task automatic host_loop(input int good, input int nak_pct);
    for (int i = 0; i < good; i++) begin
      wait_frame();
      apb_access(1'b0, ADDR_STATUS, '0);
      if ($urandom % 100 < nak_pct) begin
        apb_access(1'b1, ADDR_CMD, APB_DW'(CMD_NAK));
        wait_frame();
        apb_access(1'b0, ADDR_STATUS, '0);
      end
      apb_access(1'b1, ADDR_CMD, APB_DW'(CMD_ACK));
    end
  endtask

  task automatic run_traffic(input int frames, input int bad_pct, input int nak_pct,
                             input logic fill);
    logic bad[$];
    int   good;
    logic full;
    good = 0;
    for (int i = 0; i < frames; i++) begin
      bad.push_back($urandom % 100 < bad_pct);
      if (!bad[i]) begin
        good++;
      end
    end
    stall = fill;
    fork
      foreach (bad[i]) send_frame(bad[i], fill);
      begin
        if (fill) begin
          full = 1'b0;
          for (int t = 0; t < TMO && !full; t++) begin
            full = !s_tready;
            @(posedge clock);
            #2;
          end
          if (!full) begin
            finish_run("timeout: FIFO never filled under back-pressure");
          end
          apb_access(1'b0, ADDR_STATUS, '0);
          stall = 1'b0;
        end
        host_loop(good, nak_pct);
      end
    join
    apb_access(1'b0, ADDR_OK_COUNT, '0);
    apb_access(1'b0, ADDR_DROP_COUNT, '0);
  endtask

  initial begin
    void'($urandom(32'h2a3c));
    reset    = 1'b1;
    s_tvalid = 1'b0;
    s_tkeep  = 1'b0;
    s_tlast  = 1'b0;
    s_tdata  = '0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    repeat (8) @(posedge clock);
    #2;
    reset = 1'b0;

    phase = 1;
    run_traffic(30, 25, 0, 1'b0);
    phase = 2;
    run_traffic(20, 20, 40, 1'b0);

    phase = 3;
    apb_access(1'b0, ADDR_STATUS, '0);
    apb_access(1'b0, ADDR_OK_COUNT, '0);
    apb_access(1'b0, ADDR_DROP_COUNT, '0);
    apb_access(1'b0, ADDR_CMD, '0);

    // Error responses while a frame is held, then release it
    phase = 4;
    send_frame(1'b0, 1'b0);
    wait_frame();
    apb_access(1'b0, 4'h2, '0);
    apb_access(1'b1, ADDR_OK_COUNT, 32'h5);
    apb_access(1'b1, ADDR_CMD, 32'h07);
    repeat (10) begin
      @(posedge clock);
      #2;
    end
    apb_access(1'b0, ADDR_STATUS, '0);
    apb_access(1'b1, ADDR_CMD, APB_DW'(CMD_ACK));

    phase = 5;
    run_traffic(8, 0, 0, 1'b1);

    phase = 6;
    repeat (2) begin
      @(posedge clock);
      #2;
    end
    finish_run("");
  end

endmodule

// File: src.f
hdl/link_pkg.sv
hdl/csr_pkg.sv
hdl/crc8_check.sv
hdl/axis_skid.sv
hdl/packet_fifo.sv
hdl/link_csr.sv
hdl/link_rx_top.sv
verif/link_assertions.sv
verif/link_checker.sv
verif/link_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator and run; the result is judged from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module link_tb -f src.f -o link_sim \
  && ./obj_dir/link_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
